//--- hdl/spriteFetchPkg.sv
/* word addressed read-only SRAM; sprite rows use only the low 5 bits of the line number
   and image base addresses assume 480 lines of 40 words each */
package spriteFetchPkg;

	// raw widths
	localparam int sramAddrBits = 20;
	localparam int sramWordBits = 16;
	localparam int lineIdxBits = 9;
	localparam int wordIdxBits = 6;
	localparam int spriteIdxBits = 3;

	// word address on the SRAM pins
	typedef logic [sramAddrBits-1:0] sramAddrT;
	// one data word, 16 one-bit pixels
	typedef logic [sramWordBits-1:0] sramWordT;
	// screen line, 0..479
	typedef logic [lineIdxBits-1:0] lineIdxT;
	// position inside the line buffer
	typedef logic [wordIdxBits-1:0] wordIdxT;
	// bike sprite number
	typedef logic [spriteIdxBits-1:0] spriteIdxT;

	// what a line request fetches
	typedef enum logic [1:0]
	{
		menuRegion,
		backgroundRegion,
		spriteRegion
	} regionT;

	// 640 pixels at 16 per word
	localparam int screenLineWords = 40;
	// 32 pixel sprite row
	localparam int spriteLineWords = 2;
	// 32 rows of 2 words
	localparam int spriteWords = 64;
	// sprite rows per sprite, selects how much of lineNum counts
	localparam int spriteRowBits = 5;

	// memory map
	// menu image at the bottom of the SRAM
	localparam sramAddrT menuBase = 20'h00000;
	// background follows the 19200 word menu image
	localparam sramAddrT backgroundBase = 20'h04B00;
	// eight sprites after the background, 512 words in all
	localparam sramAddrT spriteBase = 20'h09600;

endpackage

//--- hdl/sramReadIf.sv
/* single word read between line fetcher and SRAM controller; readReq only when the
   controller is idle, readData valid only while readDone is high */
interface sramReadIf
	import spriteFetchPkg::*;
();

	// one cycle request pulse
	logic readReq;
	// address, valid with readReq
	sramAddrT reqAddr;
	// one cycle completion pulse
	logic readDone;
	// returned word, valid with readDone
	sramWordT readData;

	modport requester
	(
		output readReq,
		output reqAddr,
		input readDone,
		input readData
	);

	// controller side of the same bus
	modport controller
	(
		input readReq,
		input reqAddr,
		output readDone,
		output readData
	);

endinterface

//--- hdl/sramReadController.sv
/* fixed 4 cycle read of an asynchronous SRAM, no wait states; chip enable, byte lanes
   and write enable are tied on the board, requests outside idle are dropped */
module sramReadController
	import spriteFetchPkg::*;
(
	input logic Clk,
	input logic rstN,
	sramReadIf.controller bus,
	output sramAddrT sramAddr,
	output logic sramOeN,
	input sramWordT sramData
);

	typedef enum logic [2:0]
	{
		idle,
		setAddr,
		waitData,
		capture,
		done
	} ctrlStateT;

	ctrlStateT state;
	ctrlStateT nextState;
	// word sampled off the data pins
	sramWordT dataReg;
	// output enable wanted in the next cycle
	logic oeNext;

	always_comb
	begin
		// default stay put
		nextState = state;
		case (state)
			idle:
			begin
				if (bus.readReq)
					nextState = setAddr;
			end
			// address settles on the pins
			setAddr:
				nextState = waitData;
			// OE low, SRAM drives the bus
			waitData:
				nextState = capture;
			// data sampled at the end of this cycle
			capture:
				nextState = done;
			done:
				nextState = idle;
			default:
				nextState = idle;
		endcase
	end

	// enable spans waitData, capture and done
	assign oeNext = (nextState == waitData) || (nextState == capture) || (nextState == done);

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= idle;
			sramAddr <= '0;
			sramOeN <= 1'b1;
		end
		else
		begin
			state <= nextState;
			// latch once so the pins hold for the whole access
			if (state == idle && bus.readReq)
				sramAddr <= bus.reqAddr;
			// registered so OE never glitches on the pin
			sramOeN <= !oeNext;
		end
	end

	// data pins have had two OE cycles to settle
	always_ff @(posedge Clk)
	begin
		if (state == capture)
			dataReg <= sramData;
	end

	// completion pulse with the held word
	assign bus.readDone = (state == done);
	assign bus.readData = dataReg;

endmodule

//--- hdl/lineFetcher.sv
/* fetches one screen line (40 words) or one sprite row (2 words) into the line buffer;
   a lineStart while busy is dropped, sprite rows use lineNum bits 4:0 only */
module lineFetcher
	import spriteFetchPkg::*;
(
	input logic Clk,
	input logic rstN,
	input logic lineStart,
	input regionT region,
	input spriteIdxT spriteIdx,
	input lineIdxT lineNum,
	sramReadIf.requester bus,
	output logic wrEn,
	output wordIdxT wrIdx,
	output sramWordT wrData,
	output logic lineBusy,
	output logic lineDone,
	output wordIdxT lineWords
);

	typedef enum logic [1:0]
	{
		idle,
		request,
		waitWord,
		finish
	} fetchStateT;

	fetchStateT state;
	// start address and length worked out from the request
	sramAddrT startAddr;
	wordIdxT startCount;
	// registered copies for the running line
	sramAddrT baseAddr;
	wordIdxT wordCount;
	// word being fetched
	wordIdxT wordCnt;
	logic lastWord;

	always_comb
	begin
		case (region)
			menuRegion:
			begin
				startAddr = menuBase + sramAddrT'(lineNum) * sramAddrT'(screenLineWords);
				startCount = wordIdxT'(screenLineWords);
			end
			backgroundRegion:
			begin
				startAddr = backgroundBase + sramAddrT'(lineNum) * sramAddrT'(screenLineWords);
				startCount = wordIdxT'(screenLineWords);
			end
			spriteRegion:
			begin
				// sprite block, then row inside it
				startAddr = spriteBase + sramAddrT'(spriteIdx) * sramAddrT'(spriteWords)
					+ sramAddrT'(lineNum[spriteRowBits-1:0]) * sramAddrT'(spriteLineWords);
				startCount = wordIdxT'(spriteLineWords);
			end
			default:
			begin
				startAddr = menuBase;
				startCount = wordIdxT'(screenLineWords);
			end
		endcase
	end

	assign lastWord = (wordCnt == wordIdxT'(wordCount - 1'b1));

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= idle;
			wordCnt <= '0;
			wordCount <= '0;
			lineWords <= '0;
		end
		else
		begin
			case (state)
				idle:
				begin
					// new line only accepted here
					if (lineStart)
					begin
						wordCount <= startCount;
						wordCnt <= '0;
						state <= request;
					end
				end
				// readReq goes out for exactly this cycle
				request:
					state <= waitWord;
				waitWord:
				begin
					if (bus.readDone)
					begin
						if (lastWord)
							state <= finish;
						else
						begin
							wordCnt <= wordCnt + 1'b1;
							state <= request;
						end
					end
				end
				finish:
				begin
					lineWords <= wordCount;
					state <= idle;
				end
				default:
					state <= idle;
			endcase
		end
	end

	// base only matters while the line runs
	always_ff @(posedge Clk)
	begin
		if (state == idle && lineStart)
			baseAddr <= startAddr;
	end

	assign bus.readReq = (state == request);
	assign bus.reqAddr = baseAddr + sramAddrT'(wordCnt);

	// word goes to the buffer on the readDone cycle
	assign wrEn = (state == waitWord) && bus.readDone;
	assign wrIdx = wordCnt;
	assign wrData = bus.readData;

	// busy drops as done pulses
	assign lineBusy = (state == request) || (state == waitWord);
	assign lineDone = (state == finish);

endmodule

//--- hdl/lineBuffer.sv
/* 40 word line store, one cycle read latency; contents undefined until a line has
   finished and undefined for rdIdx 40 and above */
module lineBuffer
	import spriteFetchPkg::*;
(
	input logic Clk,
	input logic wrEn,
	input wordIdxT wrIdx,
	input sramWordT wrData,
	input wordIdxT rdIdx,
	output sramWordT rdData
);

	// one entry per word of a full screen line
	sramWordT mem [screenLineWords];
	// index bounds
	logic wrInRange;
	logic rdInRange;

	// 6 bit index reaches past the 40 entries
	assign wrInRange = (wrIdx < wordIdxT'(screenLineWords));
	assign rdInRange = (rdIdx < wordIdxT'(screenLineWords));

	// write port from the fetcher
	always_ff @(posedge Clk)
	begin
		if (wrEn && wrInRange)
			mem[wrIdx] <= wrData;
	end

	// registered read for the pixel pipeline
	always_ff @(posedge Clk)
	begin
		if (rdInRange)
			rdData <= mem[rdIdx];
		else
			rdData <= '0;
	end

endmodule

//--- hdl/spriteFetchTop.sv
/* SRAM line fetch path for the draw engine; rdData is only meaningful while lineBusy
   is low, after lineDone */
module spriteFetchTop
	import spriteFetchPkg::*;
(
	input logic Clk,
	input logic rstN,
	// line request from the draw engine
	input logic lineStart,
	input regionT region,
	input spriteIdxT spriteIdx,
	input lineIdxT lineNum,
	// buffer readback
	input wordIdxT rdIdx,
	output sramWordT rdData,
	// SRAM pins
	output sramAddrT sramAddr,
	output logic sramOeN,
	input sramWordT sramData,
	// line status
	output logic lineBusy,
	output logic lineDone,
	output wordIdxT lineWords
);

	// fetcher to controller
	sramReadIf readBus();

	// fetcher to buffer write port
	logic wrEn;
	wordIdxT wrIdx;
	sramWordT wrData;

	lineFetcher lineFetcher_inst
	(
		.Clk(Clk),
		.rstN(rstN),
		.lineStart(lineStart),
		.region(region),
		.spriteIdx(spriteIdx),
		.lineNum(lineNum),
		.bus(readBus.requester),
		.wrEn(wrEn),
		.wrIdx(wrIdx),
		.wrData(wrData),
		.lineBusy(lineBusy),
		.lineDone(lineDone),
		.lineWords(lineWords)
	);

	sramReadController sramReadController_inst
	(
		.Clk(Clk),
		.rstN(rstN),
		.bus(readBus.controller),
		.sramAddr(sramAddr),
		.sramOeN(sramOeN),
		.sramData(sramData)
	);

	lineBuffer lineBuffer_inst
	(
		.Clk(Clk),
		.wrEn(wrEn),
		.wrIdx(wrIdx),
		.wrData(wrData),
		.rdIdx(rdIdx),
		.rdData(rdData)
	);

endmodule

//--- bench/clockGen.sv
/* free running clock with period 4; reset low until the 16th rising edge */
module clockGen
(
	output logic Clk,
	output logic rstN
);

	initial
	begin
		Clk = 1'b0;
		forever
			#2 Clk = ~Clk;
	end

	// release on a rising edge like any other input
	initial
	begin
		rstN = 1'b0;
		repeat (16) @(posedge Clk);
		rstN <= 1'b1;
	end

endmodule

//--- bench/spriteFetchMonitor.sv
/* expects word = addr[15:0] ^ addr[19:16] ^ A5C3 at every SRAM address; one test open
   at a time, readback flagged by readActive with the buffer's one cycle latency */
module spriteFetchMonitor
	import spriteFetchPkg::*;
(
	input logic Clk,
	input logic rstN,
	input sramAddrT sramAddr,
	input logic sramOeN,
	input logic lineBusy,
	input logic lineDone,
	input wordIdxT lineWords,
	input wordIdxT rdIdx,
	input sramWordT rdData,
	input logic readActive,
	output int passCount,
	output int failCount
);

	string testName;
	sramAddrT expBase;
	int expCount;
	int addrSeen;
	int doneSeen;
	int testErrors;
	logic testOpen;
	logic prevOeN;
	// readback index presented last cycle
	logic pendValid;
	wordIdxT pendIdx;

	initial
	begin
		passCount = 0;
		failCount = 0;
		testOpen = 1'b0;
	end

	// board SRAM contents
	function automatic sramWordT expectedWord(sramAddrT addr);
		return addr[15:0] ^ {12'h000, addr[19:16]} ^ 16'hA5C3;
	endfunction

	task automatic reportMismatch(string what, logic [31:0] expected, logic [31:0] actual);
		$display("[ERROR] %s %s expected %h actual %h", testName, what, expected, actual);
		testErrors++;
	endtask

	task automatic closeTest();
		testOpen = 1'b0;
		if (testErrors == 0)
		begin
			passCount++;
			$display("PASS %s", testName);
		end
		else
		begin
			failCount++;
			$display("FAIL %s with %0d errors", testName, testErrors);
		end
	endtask

	task automatic startTest(string name, sramAddrT base, int count);
		testName = name;
		expBase = base;
		expCount = count;
		addrSeen = 0;
		doneSeen = 0;
		testErrors = 0;
		testOpen = 1'b1;
	endtask

	task automatic finishTest();
		if (addrSeen != expCount)
			reportMismatch("read count", expCount, addrSeen);
		if (doneSeen != 1)
			reportMismatch("lineDone pulses", 1, doneSeen);
		if (lineWords !== wordIdxT'(expCount))
			reportMismatch("lineWords", expCount, lineWords);
		closeTest();
	endtask

	task automatic failTest(string name, string why);
		testOpen = 1'b0;
		failCount++;
		$display("FAIL %s: %s", name, why);
	endtask

	// idle outputs before any request
	task automatic checkIdleState(string name);
		testName = name;
		testErrors = 0;
		if (sramOeN !== 1'b1)
			reportMismatch("sramOeN", 1, sramOeN);
		if (lineBusy !== 1'b0)
			reportMismatch("lineBusy", 0, lineBusy);
		if (lineDone !== 1'b0)
			reportMismatch("lineDone", 0, lineDone);
		if (sramAddr !== '0)
			reportMismatch("sramAddr", 0, sramAddr);
		closeTest();
	endtask

	always @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			prevOeN = 1'b1;
			pendValid = 1'b0;
			pendIdx = '0;
		end
		else
		begin
			// one address per access, taken as OE falls
			if (!sramOeN && prevOeN)
			begin
				if (!testOpen)
				begin
					failCount++;
					$display("SRAM read at address %h outside any test", sramAddr);
				end
				else if (addrSeen >= expCount)
				begin
					testErrors++;
					$display("%s: extra SRAM read at address %h", testName, sramAddr);
				end
				else if (sramAddr !== expBase + sramAddrT'(addrSeen))
					reportMismatch("sramAddr", expBase + sramAddrT'(addrSeen), sramAddr);
				// every read of a line happens while busy
				if (testOpen && lineBusy !== 1'b1)
					reportMismatch("lineBusy during read", 1, lineBusy);
				addrSeen++;
			end
			if (testOpen && lineDone)
			begin
				doneSeen++;
				// busy already low in the done cycle
				if (lineBusy !== 1'b0)
					reportMismatch("lineBusy at lineDone", 0, lineBusy);
			end
			// word for the index of the previous cycle
			if (testOpen && pendValid && rdData !== expectedWord(expBase + sramAddrT'(pendIdx)))
				reportMismatch($sformatf("rdData[%0d]", pendIdx),
					expectedWord(expBase + sramAddrT'(pendIdx)), rdData);
			pendValid = readActive;
			pendIdx = rdIdx;
			prevOeN = sramOeN;
		end
	end

endmodule

//--- bench/spriteFetch_checker.sv
/* bound into sramReadController; assumes readReq only arrives while the controller is idle */
module spriteFetchChecker
	import spriteFetchPkg::*;
(
	input logic Clk,
	input logic rstN,
	input logic readReq,
	input logic readDone,
	input logic sramOeN,
	input sramAddrT sramAddr
);

	// OE low for waitData, capture and done only
	oeWindow: assert property (@(posedge Clk) disable iff (!rstN)
		readReq |-> sramOeN ##1 sramOeN ##1 !sramOeN [*3] ##1 sramOeN)
		else $error("sramOeN not low for exactly three cycles after readReq");

	// no OE without a request two cycles back
	oeOnlyAfterReq: assert property (@(posedge Clk) disable iff (!rstN)
		$fell(sramOeN) |-> $past(readReq, 2))
		else $error("sramOeN fell without a preceding readReq");

	donePulse: assert property (@(posedge Clk) disable iff (!rstN)
		readDone |=> !readDone)
		else $error("readDone high for more than one cycle");

	// request to done is four cycles
	doneLatency: assert property (@(posedge Clk) disable iff (!rstN)
		readReq |-> ##1 !readDone [*3] ##1 readDone)
		else $error("readDone did not follow readReq by four cycles");

	// pins must not move during the access
	addrSteady: assert property (@(posedge Clk) disable iff (!rstN)
		!sramOeN |=> (sramOeN || $stable(sramAddr)))
		else $error("sramAddr changed while sramOeN was low");

endmodule

bind sramReadController spriteFetchChecker spriteFetchChecker_inst
(
	.Clk(Clk),
	.rstN(rstN),
	.readReq(bus.readReq),
	.readDone(bus.readDone),
	.sramOeN(sramOeN),
	.sramAddr(sramAddr)
);

//--- bench/spriteFetchTb.sv
/* stimulus from bench/spriteFetch_testdata.txt, run from the project root; the SRAM
   model drives the data pins only while OE is low */
module spriteFetchTb
	import spriteFetchPkg::*;
();

	logic Clk;
	logic rstN;
	logic lineStart;
	regionT region;
	spriteIdxT spriteIdx;
	lineIdxT lineNum;
	wordIdxT rdIdx;
	sramWordT rdData;
	sramAddrT sramAddr;
	logic sramOeN;
	sramWordT sramData;
	logic lineBusy;
	logic lineDone;
	wordIdxT lineWords;
	logic readActive;
	int passCount;
	int failCount;
	logic aborted;

	clockGen clockGen_inst (.*);
	spriteFetchTop spriteFetchTop_inst (.*);
	spriteFetchMonitor spriteFetchMonitor_inst (.*);

	// board SRAM answers only while OE is low
	assign sramData = sramOeN ? 'x : (sramAddr[15:0] ^ {12'h000, sramAddr[19:16]} ^ 16'hA5C3);

	// sel 0 waits for rstN, 1 for lineBusy, 2 for lineDone
	task automatic waitHigh(input int sel, input int limit, output logic seen);
		int cycles;
		seen = 1'b0;
		for (cycles = 0; cycles < limit && !seen; cycles++)
		begin
			@(posedge Clk);
			seen = (sel == 0) ? rstN : ((sel == 1) ? lineBusy : lineDone);
		end
	endtask

	task automatic runLineTest(string name, int regionVal, int spriteVal, int lineVal,
		logic [31:0] baseVal, int countVal, int restartVal);
		logic seen;
		int i;
		spriteFetchMonitor_inst.startTest(name, sramAddrT'(baseVal), countVal);
		@(posedge Clk);
		lineStart <= 1'b1;
		region <= regionT'(regionVal);
		spriteIdx <= spriteIdxT'(spriteVal);
		lineNum <= lineIdxT'(lineVal);
		@(posedge Clk);
		lineStart <= 1'b0;
		if (restartVal != 0)
		begin
			waitHigh(1, 20, seen);
			if (!seen)
			begin
				spriteFetchMonitor_inst.failTest(name, "lineBusy did not rise within 20 cycles");
				aborted = 1'b1;
			end
			else
			begin
				// different request the busy fetcher has to drop
				lineStart <= 1'b1;
				region <= spriteRegion;
				spriteIdx <= spriteIdxT'(spriteVal + 3);
				lineNum <= lineIdxT'(lineVal + 5);
				@(posedge Clk);
				lineStart <= 1'b0;
			end
		end
		if (!aborted)
		begin
			waitHigh(2, 400, seen);
			if (!seen)
			begin
				spriteFetchMonitor_inst.failTest(name,
					"lineDone did not arrive within 400 cycles");
				aborted = 1'b1;
			end
			else
			begin
				// one index per cycle, starting on the done edge
				for (i = 0; i < countVal; i++)
				begin
					rdIdx <= wordIdxT'(i);
					readActive <= 1'b1;
					@(posedge Clk);
				end
				readActive <= 1'b0;
				// last word reaches the monitor two edges later
				repeat (2) @(posedge Clk);
				@(negedge Clk);
				spriteFetchMonitor_inst.finishTest();
			end
		end
	endtask

	initial
	begin
		int fd;
		int n;
		string line;
		string name;
		int regionVal;
		int spriteVal;
		int lineVal;
		int countVal;
		int restartVal;
		logic [31:0] baseVal;
		logic seen;
		fd = 0;
		lineStart = 1'b0;
		region = menuRegion;
		spriteIdx = '0;
		lineNum = '0;
		rdIdx = '0;
		readActive = 1'b0;
		aborted = 1'b0;
		waitHigh(0, 100, seen);
		if (!seen)
		begin
			spriteFetchMonitor_inst.failTest("reset", "rstN was never released");
			aborted = 1'b1;
		end
		else
		begin
			@(negedge Clk);
			spriteFetchMonitor_inst.checkIdleState("after_reset");
			fd = $fopen("bench/spriteFetch_testdata.txt", "r");
			if (fd == 0)
			begin
				spriteFetchMonitor_inst.failTest("testdata", "could not open the data file");
				aborted = 1'b1;
			end
		end
		while (!aborted && !$feof(fd))
		begin
			n = $fgets(line, fd);
			// skip comment and blank lines
			if (n > 0 && line.getc(0) != "#")
			begin
				n = $sscanf(line, "%s %d %d %d %h %d %d", name, regionVal, spriteVal, lineVal,
					baseVal, countVal, restartVal);
				if (n == 7)
					runLineTest(name, regionVal, spriteVal, lineVal, baseVal, countVal, restartVal);
			end
		end
		if (fd != 0)
			$fclose(fd);
		$display("%0d tests passed, %0d tests failed", passCount, failCount);
		if (failCount == 0 && passCount > 1)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- bench/spriteFetch_testdata.txt
# name region spriteIdx lineNum base(hex) words restart
# region 0 menu, 1 background, 2 sprite; restart 1 pulses a second lineStart while busy
menu_line0 0 0 0 00000 40 0
menu_line1 0 0 1 00028 40 0
bg_line100 1 0 100 05AA0 40 0
sprite3_row5 2 3 5 096CA 2 0
bg_line479 1 0 479 095D8 40 0
sprite7_row31 2 7 31 097FE 2 0
menu_line479 0 0 479 04AD8 40 0
sprite0_row0 2 0 0 09600 2 0
sprite5_row12 2 5 12 09758 2 0
bg_line0_restart 1 0 0 04B00 40 1
sprite1_row31_restart 2 1 31 0967E 2 1
bg_line7 1 0 7 04C18 40 0
sprite6_row20 2 6 20 097A8 2 0

//--- spriteFetch.f
hdl/spriteFetchPkg.sv
hdl/sramReadIf.sv
hdl/sramReadController.sv
hdl/lineFetcher.sv
hdl/lineBuffer.sv
hdl/spriteFetchTop.sv
bench/clockGen.sv
bench/spriteFetchMonitor.sv
bench/spriteFetch_checker.sv
bench/spriteFetchTb.sv
